// ==== filelist.f ====
+incdir+.
i2cPkg.sv
i2cCmdIf.sv
i2cClockEnable.sv
i2cMaster.sv
i2cAxiRegs.sv
i2cTop.sv
tbClock.sv
i2c_properties.sv
i2cTb.sv

// ==== i2cAxiRegs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_config.svh"

// axi4-lite slave, byte buffer and control for the engine
module i2cAxiRegs (
	input  logic                 iCLK,
	input  logic                 iRST,
	input  logic [`AXI_AW-1:0]   awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  logic [`AXI_DW-1:0]   wdata,
	input  logic [`AXI_DW/8-1:0] wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output i2cPkg::axiResp       bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  logic [`AXI_AW-1:0]   araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output logic [`AXI_DW-1:0]   rdata,
	output i2cPkg::axiResp       rresp,
	output logic                 rvalid,
	input  logic                 rready,
	i2cCmdIf.regs                cmd
);
	import i2cPkg::*;

	localparam int IW = $clog2(`BUF_DEPTH);

	logic [7:0]         txBuf [`BUF_DEPTH];
	logic [`LEN_W-1:0]  lenQ;
	logic [IW-1:0]      rdIdx;   // slot shown to the engine
	logic               doneSt;  // sticky until next go
	logic               nackSt;
	logic               wrFire;
	logic               rdFire;
	logic [`AXI_AW-1:0] wrOff;
	logic [`AXI_AW-1:0] rdOff;
	logic               wrInBuf;
	logic               rdInBuf;
	logic               wrKnown;
	logic               rdKnown;

	assign wrFire  = awready && awvalid && wvalid; // aw and w taken together
	assign rdFire  = arready && arvalid;
	assign wready  = awready;
	assign wrOff   = awaddr - dataBase;
	assign rdOff   = araddr - dataBase;
	assign wrInBuf = (awaddr >= dataBase) && (wrOff < `BUF_DEPTH);
	assign rdInBuf = (araddr >= dataBase) && (rdOff < `BUF_DEPTH);
	assign wrKnown = wrInBuf || (awaddr inside {ctrlReg, lenReg, statReg});
	assign rdKnown = rdInBuf || (araddr inside {ctrlReg, lenReg, statReg});

	assign cmd.txByte = txBuf[rdIdx];
	assign cmd.txLen  = lenQ;

	// ----------------------------------------
	// handshakes
	// ----------------------------------------
	always_ff @(posedge iCLK) begin
		if (iRST) begin
			awready <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= okay;
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rresp   <= okay;
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid; // 1-cycle pulse
			arready <= arvalid && !arready && !rvalid;
			if (wrFire) begin
				bvalid <= 1'b1;
				bresp  <= wrKnown ? okay : slvErr;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rdFire) begin
				rvalid <= 1'b1;
				rresp  <= rdKnown ? okay : slvErr;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// ----------------------------------------
	// control, status, read index
	// ----------------------------------------
	always_ff @(posedge iCLK) begin
		if (iRST) begin
			cmd.start <= 1'b0;
			lenQ      <= '0;
			doneSt    <= 1'b0;
			nackSt    <= 1'b0;
			rdIdx     <= '0;
		end else begin
			cmd.start <= 1'b0;
			if (wrFire && wstrb[0]) begin
				case (awaddr)
					ctrlReg: begin
						if (wdata[0] && !cmd.busy) begin // go ignored while busy
							cmd.start <= 1'b1;
							doneSt    <= 1'b0;
							nackSt    <= 1'b0;
						end
					end
					lenReg:  lenQ <= wdata[`LEN_W-1:0];
					default: ;
				endcase
			end
			if (cmd.doneEv) begin
				doneSt <= 1'b1;
			end
			if (cmd.nack) begin
				nackSt <= 1'b1;
			end
			if (cmd.start) begin
				rdIdx <= '0; // rewind for new transfer
			end else if (cmd.nextByte) begin
				rdIdx <= rdIdx + 1'b1;
			end
		end
	end

	// byte buffer, low byte lane only
	always_ff @(posedge iCLK) begin
		if (wrFire && wstrb[0] && wrInBuf) begin
			txBuf[wrOff[IW-1:0]] <= wdata[7:0];
		end
	end

	// read data mux
	always_ff @(posedge iCLK) begin
		if (rdFire) begin
			case (araddr)
				lenReg:  rdata <= `AXI_DW'(lenQ);
				// done already shows in the cycle busy drops
				statReg: rdata <= `AXI_DW'({nackSt, doneSt | cmd.doneEv, cmd.busy});
				default: rdata <= rdInBuf ? `AXI_DW'(txBuf[rdOff[IW-1:0]]) : '0; // ctrl reads 0
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== i2cClockEnable.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_config.svh"

// quarter-bit enable, one pulse every CLK_DIV clocks
module i2cClockEnable (
	input  logic iCLK,
	input  logic iRST,
	input  logic run,  // engine busy
	output logic enClk
);

	localparam int CW = $clog2(`CLK_DIV);

	logic [CW-1:0] divCnt;

	always_ff @(posedge iCLK) begin
		// held cleared when idle so each transfer starts phase-aligned
		if (iRST || !run) begin
			divCnt <= '0;
			enClk  <= 1'b0;
		end else begin
			enClk <= (divCnt == CW'(`CLK_DIV - 1)); // one cycle wide
			if (divCnt == CW'(`CLK_DIV - 1)) begin
				divCnt <= '0;
			end else begin
				divCnt <= divCnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== i2cCmdIf.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_config.svh"

// register block to bit engine
interface i2cCmdIf;
	logic [7:0]        txByte;   // buffer slot at read index
	logic [`LEN_W-1:0] txLen;    // bytes to send
	logic              start;    // one-cycle go
	logic              nextByte; // engine took txByte
	logic              busy;
	logic              doneEv;   // end of stop condition
	logic              nack;     // ack sample read high

	modport regs (
		output txByte, txLen, start,
		input  nextByte, busy, doneEv, nack
	);

	modport engine (
		input  txByte, txLen, start,
		output nextByte, busy, doneEv, nack
	);
endinterface

`default_nettype wire

// ==== i2cMaster.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_config.svh"

// write-only i2c bit engine, open-drain enables (1 = pull low)
module i2cMaster (
	input  logic    iCLK,
	input  logic    iRST,
	input  logic    enClk,
	i2cCmdIf.engine cmd,
	output logic    sclOe,
	output logic    sdaOe,
	input  logic    sdaIn
);
	import i2cPkg::*;

	localparam int HW = $clog2(`SDA_HOLD + 1);

	i2cState           state;
	logic [1:0]        phase;    // quarter bit: low, low, high, high
	logic [2:0]        bitCnt;   // bits left in byte
	logic [`LEN_W-1:0] byteCnt;  // index of byte on the wire
	logic [HW-1:0]     holdCnt;  // counts down after scl falls
	logic [7:0]        shiftReg;
	logic              sdaWant;  // sda level for after the hold
	logic              lastByte;

	assign cmd.busy = (state != idle);
	assign lastByte = (byteCnt + 1'b1 >= cmd.txLen); // len 0 acts as 1

	// ----------------------------------------
	// sda target per state
	// ----------------------------------------
	always_comb begin
		case (state)
			dataBit:  sdaWant = ~shiftReg[7]; // release for a one
			ackBit:   sdaWant = 1'b0;         // slave owns sda
			stopCond: sdaWant = 1'b1;         // low ahead of stop edge
			default:  sdaWant = sdaOe;
		endcase
	end

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_ff @(posedge iCLK) begin
		if (iRST) begin
			state        <= idle;
			phase        <= 2'd0;
			bitCnt       <= 3'd0;
			byteCnt      <= '0;
			holdCnt      <= '0;
			sclOe        <= 1'b0; // both lines float high
			sdaOe        <= 1'b0;
			cmd.nextByte <= 1'b0;
			cmd.doneEv   <= 1'b0;
			cmd.nack     <= 1'b0;
		end else begin
			cmd.nextByte <= 1'b0;
			cmd.doneEv   <= 1'b0;
			cmd.nack     <= 1'b0;

			// delayed sda change, SDA_HOLD clocks after scl fall
			if (holdCnt != '0) begin
				holdCnt <= holdCnt - 1'b1;
				if (holdCnt == HW'(1)) begin
					sdaOe <= sdaWant;
				end
			end

			case (state)
				idle: begin
					sclOe <= 1'b0;
					sdaOe <= 1'b0;
					phase <= 2'd0;
					if (cmd.start) begin
						byteCnt <= '0;
						state   <= startCond;
					end
				end

				startCond: begin
					if (enClk) begin
						phase <= phase + 1'b1;
						case (phase)
							2'd0: begin
								shiftReg     <= cmd.txByte; // address + write bit
								cmd.nextByte <= 1'b1;
							end
							2'd1: sdaOe <= 1'b1; // start edge, scl still high
							2'd3: begin
								sclOe   <= 1'b1;
								holdCnt <= HW'(`SDA_HOLD);
								bitCnt  <= 3'd7;
								state   <= dataBit;
							end
							default: ;
						endcase
					end
				end

				// data and ack share the scl pattern
				dataBit, ackBit: begin
					if (enClk) begin
						phase <= phase + 1'b1;
						if (phase == 2'd1) begin
							sclOe <= 1'b0; // scl rises
						end
						if (phase == 2'd3) begin
							sclOe   <= 1'b1; // scl falls, end of bit
							holdCnt <= HW'(`SDA_HOLD);
							if (state == dataBit) begin
								shiftReg <= {shiftReg[6:0], 1'b0};
								bitCnt   <= bitCnt - 1'b1;
								if (bitCnt == 3'd0) begin
									state <= ackBit;
								end
							end else if (sdaIn) begin
								cmd.nack <= 1'b1; // nack, abort
								state    <= stopCond;
							end else if (lastByte) begin
								state <= stopCond;
							end else begin
								byteCnt      <= byteCnt + 1'b1;
								shiftReg     <= cmd.txByte;
								cmd.nextByte <= 1'b1;
								bitCnt       <= 3'd7;
								state        <= dataBit;
							end
						end
					end
				end

				stopCond: begin
					if (enClk) begin
						phase <= phase + 1'b1;
						case (phase)
							2'd1: sclOe <= 1'b0; // scl up, sda held low
							2'd2: sdaOe <= 1'b0; // stop edge
							2'd3: begin
								cmd.doneEv <= 1'b1; // bus free time done
								state      <= idle;
							end
							default: ;
						endcase
					end
				end

				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== i2cPkg.sv ====
`default_nettype none

package i2cPkg;

	// ----------------------------------------
	// bit engine states
	// ----------------------------------------
	typedef enum logic [2:0] {
		idle      = 3'd0, // bus released, waiting for go
		startCond = 3'd1, // sda falls while scl high
		dataBit   = 3'd2, // 8 bits, msb first
		ackBit    = 3'd3, // sda released, slave answers
		stopCond  = 3'd4  // sda rises while scl high
	} i2cState;

	// ----------------------------------------
	// register map
	// ----------------------------------------
	// one 32-bit register per word address
	typedef enum logic [4:0] {
		ctrlReg  = 5'd0,  // bit 0 go
		lenReg   = 5'd4,  // bytes per transfer
		statReg  = 5'd8,  // busy, done, nack
		dataBase = 5'd16  // first byte slot, one slot per address
	} regAddr;

	typedef enum logic [1:0] {
		okay   = 2'b00,
		slvErr = 2'b10 // unmapped address
	} axiResp;

endpackage

`default_nettype wire

// ==== i2cTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_config.svh"

module i2cTb;
	import i2cPkg::*;

	localparam int NUM_XFER = 20;
	// worst case bits per transfer, 4 enables per bit, x2 margin
	localparam int LIMIT = NUM_XFER * (`BUF_DEPTH * 9 + 4) * 4 * `CLK_DIV * 2;

	logic                 iCLK;
	logic                 iRST;
	logic [`AXI_AW-1:0]   awaddr;
	logic                 awvalid;
	logic                 awready;
	logic [`AXI_DW-1:0]   wdata;
	logic [`AXI_DW/8-1:0] wstrb;
	logic                 wvalid;
	logic                 wready;
	axiResp               bresp;
	logic                 bvalid;
	logic                 bready;
	logic [`AXI_AW-1:0]   araddr;
	logic                 arvalid;
	logic                 arready;
	logic [`AXI_DW-1:0]   rdata;
	axiResp               rresp;
	logic                 rvalid;
	logic                 rready;
	wire                  i2cScl;
	wire                  i2cSda;

	int errCnt   = 0;
	int cycleCnt = 0;

	// slave model state
	logic       slvPull  = 1'b0; // pulls sda low for ack
	logic       inAck    = 1'b0;
	logic [7:0] shiftIn  = 8'h00;
	int         bitPos   = 0;
	int         byteIdx  = 0;
	int         nackPos  = -1;   // byte to nack, -1 none
	int         startCnt = 0;
	int         stopCnt  = 0;
	logic [7:0] rxQ [$];

	tbClock uClk (.iCLK, .iRST);

	i2cTop UUT (.*);

	pullup (i2cScl);
	pullup (i2cSda);
	assign i2cSda = slvPull ? 1'b0 : 1'bz;

	// ----------------------------------------
	// i2c slave model
	// ----------------------------------------
	always @(negedge i2cSda) begin
		if (i2cScl === 1'b1) begin // start
			startCnt++;
			bitPos  = 0;
			byteIdx = 0;
			inAck   = 1'b0;
		end
	end

	always @(posedge i2cSda) begin
		if (i2cScl === 1'b1) begin // stop
			stopCnt++;
			bitPos = 0;
			inAck  = 1'b0;
		end
	end

	always @(posedge i2cScl) begin
		if (!inAck && bitPos < 8) begin
			shiftIn = {shiftIn[6:0], i2cSda}; // msb first
			bitPos++;
			if (bitPos == 8) begin
				rxQ.push_back(shiftIn);
			end
		end
	end

	always @(negedge i2cScl) begin
		if (inAck) begin
			slvPull = 1'b0; // ninth clock over
			inAck   = 1'b0;
			bitPos  = 0;
			byteIdx++;
		end else if (bitPos == 8) begin
			inAck   = 1'b1;
			slvPull = (byteIdx != nackPos);
		end
	end

	// watchdog
	always @(posedge iCLK) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= LIMIT) begin
			$display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
			$display("errors: %0d", errCnt + UUT.uProps.assertFails);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// axi4-lite driver
	// ----------------------------------------
	task automatic reportMismatch(input string msg);
		errCnt++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	task automatic axiWrite(input logic [`AXI_AW-1:0] addr, input logic [31:0] data,
		output axiResp resp);
		@(posedge iCLK);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= '1;
		wvalid  <= 1'b1;
		do @(posedge iCLK); while (!awready);
		if (wready !== 1'b1) reportMismatch("wready not high together with awready");
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do @(posedge iCLK); while (!bvalid); // bvalid waits one cycle
		resp = bresp;
		bready <= 1'b1;
		@(posedge iCLK);
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [`AXI_AW-1:0] addr, output logic [31:0] data,
		output axiResp resp);
		@(posedge iCLK);
		araddr  <= addr;
		arvalid <= 1'b1;
		do @(posedge iCLK); while (!arready);
		arvalid <= 1'b0;
		do @(posedge iCLK); while (!rvalid);
		data = rdata;
		resp = rresp;
		rready <= 1'b1;
		@(posedge iCLK);
		rready <= 1'b0;
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic checkReset();
		logic [31:0] rd;
		axiResp      rs;
		if (i2cScl !== 1'b1 || i2cSda !== 1'b1) reportMismatch("i2c pins not high after reset");
		if (bvalid !== 1'b0 || rvalid !== 1'b0) reportMismatch("bvalid/rvalid set after reset");
		if (bresp !== okay || rresp !== okay) reportMismatch("bresp/rresp not okay after reset");
		axiRead(statReg, rd, rs);
		if (rd !== 32'h0 || rs !== okay) reportMismatch($sformatf("status %h resp %0d", rd, rs));
		axiRead(5'd12, rd, rs); // hole in the map
		if (rs !== slvErr) reportMismatch($sformatf("unused read resp %0d", rs));
		axiWrite(5'd28, 32'h0, rs);
		if (rs !== slvErr) reportMismatch($sformatf("unused write resp %0d", rs));
	endtask

	task automatic runTransfer(input int idx);
		logic [7:0]  bytes [`BUF_DEPTH];
		logic [31:0] rd;
		axiResp      rs;
		int          len;
		int          expNack;
		int          expCnt;
		int          startBase;
		int          stopBase;
		len     = $urandom_range(`BUF_DEPTH, 1);
		expNack = ($urandom % 2) ? -1 : $urandom_range(len - 1, 0); // half with no nack
		expCnt  = (expNack >= 0) ? expNack + 1 : len;
		for (int i = 0; i < len; i++) begin
			bytes[i] = $urandom;
			axiWrite(dataBase + i, bytes[i], rs);
			if (rs !== okay) reportMismatch($sformatf("xfer %0d slot %0d write resp", idx, i));
		end
		axiWrite(lenReg, len, rs);
		// readback
		axiRead(lenReg, rd, rs);
		if (rd !== len) reportMismatch($sformatf("xfer %0d len %0d exp %0d", idx, rd, len));
		for (int i = 0; i < len; i++) begin
			axiRead(dataBase + i, rd, rs);
			if (rd !== 32'(bytes[i])) begin
				reportMismatch($sformatf("xfer %0d slot %0d got %h exp %h", idx, i, rd, bytes[i]));
			end
		end
		// arm the slave model
		nackPos = expNack;
		rxQ.delete();
		startBase = startCnt;
		stopBase  = stopCnt;
		axiWrite(ctrlReg, 32'h1, rs);
		axiRead(statReg, rd, rs);
		if (rd[0] !== 1'b1) reportMismatch($sformatf("xfer %0d not busy after go", idx));
		axiWrite(ctrlReg, 32'h1, rs); // go while busy, must be dropped
		do begin
			axiRead(statReg, rd, rs);
			if (!rd[0] && !rd[1]) reportMismatch($sformatf("xfer %0d idle without done", idx));
		end while (rd[1] !== 1'b1);
		if (rd[2:0] !== {(expNack >= 0), 1'b1, 1'b0}) begin
			reportMismatch($sformatf("xfer %0d status %b nack at %0d", idx, rd[2:0], expNack));
		end
		if (startCnt - startBase != 1 || stopCnt - stopBase != 1) begin
			reportMismatch($sformatf("xfer %0d starts %0d stops %0d", idx,
				startCnt - startBase, stopCnt - stopBase));
		end
		if (rxQ.size() != expCnt) begin
			reportMismatch($sformatf("xfer %0d got %0d bytes exp %0d", idx, rxQ.size(), expCnt));
		end else begin
			for (int i = 0; i < expCnt; i++) begin
				if (rxQ[i] !== bytes[i]) begin
					reportMismatch($sformatf("xfer %0d byte %0d got %h exp %h", idx, i,
						rxQ[i], bytes[i]));
				end
			end
		end
	endtask

	initial begin
		void'($urandom(32'h1e83_a253)); // seeds this thread once
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		wait (iRST === 1'b0);
		@(posedge iCLK);
		checkReset();
		for (int t = 0; t < NUM_XFER; t++) begin
			runTransfer(t);
		end
		repeat (4) @(posedge iCLK);
		$display("errors: %0d, assertion failures: %0d, transfers: %0d", errCnt,
			UUT.uProps.assertFails, NUM_XFER);
		if (errCnt + UUT.uProps.assertFails == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== i2cTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "i2c_config.svh"

module i2cTop (
	input  logic                 iCLK,
	input  logic                 iRST,
	input  logic [`AXI_AW-1:0]   awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  logic [`AXI_DW-1:0]   wdata,
	input  logic [`AXI_DW/8-1:0] wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output i2cPkg::axiResp       bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  logic [`AXI_AW-1:0]   araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output logic [`AXI_DW-1:0]   rdata,
	output i2cPkg::axiResp       rresp,
	output logic                 rvalid,
	input  logic                 rready,
	output wire                  i2cScl,
	inout  wire                  i2cSda
);

	logic enClk;
	logic sclOe;
	logic sdaOe;
	logic sdaIn;

	i2cCmdIf cmdBus ();

	// ----------------------------------------
	// blocks
	// ----------------------------------------
	i2cAxiRegs uRegs (.iCLK, .iRST, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid,
		.wready, .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
		.rvalid, .rready, .cmd(cmdBus.regs));

	i2cClockEnable uClkEn (.iCLK, .iRST, .run(cmdBus.busy), .enClk);

	i2cMaster uMaster (.iCLK, .iRST, .enClk, .cmd(cmdBus.engine), .sclOe, .sdaOe, .sdaIn);

	// open drain pins, pull-ups are external
	assign i2cScl = sclOe ? 1'b0 : 1'bz;
	assign i2cSda = sdaOe ? 1'b0 : 1'bz;
	assign sdaIn  = i2cSda; // ack sample path

endmodule

`default_nettype wire

// ==== i2c_config.svh ====
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// ----------------------------------------
// i2c timing
// ----------------------------------------
// system clocks per enable pulse, 4 pulses per scl bit
`define CLK_DIV 8
// cycles sda waits after scl falls, must stay below CLK_DIV
`define SDA_HOLD 3

// ----------------------------------------
// buffer and length
// ----------------------------------------
`define BUF_DEPTH 8 // byte slots
`define LEN_W 4     // length field width

// ----------------------------------------
// axi4-lite bus
// ----------------------------------------
`define AXI_AW 5
`define AXI_DW 32

`endif

// ==== i2c_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// bus rules, bound into the top level
module i2cProperties (
	input logic           iCLK,
	input logic           iRST,
	input logic           awvalid,
	input logic           awready,
	input logic           bvalid,
	input logic           bready,
	input logic           i2cScl,
	input logic           i2cSda,
	input i2cPkg::i2cState engState
);
	import i2cPkg::*;

	int assertFails = 0; // read by the testbench summary

	// ----------------------------------------
	// axi4-lite handshake
	// ----------------------------------------
	awreadyNeedsValid: assert property (@(posedge iCLK) disable iff (iRST)
		awready |-> awvalid)
		else begin
			assertFails++;
			$error("awready high without awvalid");
		end

	bvalidHolds: assert property (@(posedge iCLK) disable iff (iRST)
		(bvalid && !bready) |=> bvalid)
		else begin
			assertFails++;
			$error("bvalid dropped before bready");
		end

	// sda only moves under high scl for start and stop edges
	sdaStableHigh: assert property (@(posedge iCLK) disable iff (iRST)
		($past(i2cScl) && i2cScl && !(engState inside {startCond, stopCond}))
		|-> $stable(i2cSda))
		else begin
			assertFails++;
			$error("sda changed while scl high");
		end

endmodule

bind i2cTop i2cProperties uProps (.iCLK, .iRST, .awvalid, .awready, .bvalid, .bready,
	.i2cScl, .i2cSda, .engState(uMaster.state));

`default_nettype wire

// ==== tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

// testbench clock and synchronous reset
module tbClock (
	output logic iCLK,
	output logic iRST
);

	initial begin
		iCLK = 1'b0;
		forever #20 iCLK = ~iCLK; // 40 ns period
	end

	initial begin
		iRST = 1'b1;
		repeat (4) @(posedge iCLK); // held for 4 cycles
		iRST <= 1'b0;
	end

endmodule

`default_nettype wire
